//--- design/hps_pkg.sv
// shared definitions for the host-link endpoint
// bus widths, command codes, keyboard special sequences and packed structs
package hps_pkg;

	localparam int WORD_W     = 16;
	localparam int WORD_IDX_W = 4;
	localparam int JOY_W      = 32;
	localparam int STATUS_W   = 64;
	localparam int ADDR_W     = 27;

	typedef logic [WORD_W-1:0] uio_cmd_t;
	// file-I/O commands only look at the low byte of the command word
	typedef logic [7:0] fio_cmd_t;

	////////////////////////////////////////////////////////////////////
	// command codes

	localparam uio_cmd_t UIO_CFG        = 16'h0001;
	localparam uio_cmd_t UIO_JOY0       = 16'h0002;
	localparam uio_cmd_t UIO_JOY1       = 16'h0003;
	localparam uio_cmd_t UIO_KBD        = 16'h0005;
	localparam uio_cmd_t UIO_STATUS     = 16'h001E;
	localparam uio_cmd_t UIO_STATUS_REQ = 16'h0029;

	localparam fio_cmd_t FIO_FILE_TX     = 8'h53;
	localparam fio_cmd_t FIO_FILE_TX_DAT = 8'h54;
	localparam fio_cmd_t FIO_FILE_INDEX  = 8'h55;

	// raw scancode sequences that do not fit the make/break scheme
	localparam logic [31:0] KEY_PRNSCR_DN      = 32'hE012_E07C;
	localparam logic [31:0] KEY_PRNSCR_UP      = 32'h7CE0_F012;
	localparam logic [31:0] KEY_PAUSE_DN       = 32'hF014_F077;
	localparam logic [9:0]  KEY_PRNSCR_DN_CODE = 10'h37C;
	localparam logic [9:0]  KEY_PRNSCR_UP_CODE = 10'h17C;
	localparam logic [9:0]  KEY_PAUSE_DN_CODE  = 10'h377;

	////////////////////////////////////////////////////////////////////
	// structs

	typedef struct packed {
		logic              io_strobe;
		logic              io_enable;
		logic              fp_enable;
		logic [WORD_W-1:0] io_din;
	} hps_bus_t;

	typedef struct packed {
		logic                  start;
		logic                  word;
		logic                  done;
		logic [WORD_IDX_W-1:0] idx;
	} frame_ctl_t;

	typedef struct packed {
		logic [1:0] buttons;
		logic       forced_scandoubler;
		logic       direct_video;
	} ui_cfg_t;

	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic       extended;
		logic [7:0] code;
	} key_evt_t;

	typedef struct packed {
		logic              download;
		logic              wr;
		logic [15:0]       index;
		logic [ADDR_W-1:0] addr;
		logic [7:0]        dout;
	} ioctl_t;

endpackage

//--- design/cmd_framer.sv
// frame tracker for one host channel
// splits strobes into command word, payload words and frame end
`timescale 1ns/100ps

module cmd_framer import hps_pkg::*; #(
	parameter type cmd_t = uio_cmd_t
) (
	input  logic              clk_sys,
	input  logic              rst_n,
	input  logic              enable,
	input  logic              strobe,
	input  logic [WORD_W-1:0] din,
	output frame_ctl_t        ctl,
	output cmd_t              cmd
);

	logic                  active;
	cmd_t                  cmd_q;
	logic [WORD_IDX_W-1:0] idx_q;

	// first strobe of a frame is the command, the rest are payload
	always_comb begin
		ctl.start = enable & strobe & ~active;
		ctl.word  = enable & strobe & active;
		ctl.done  = ~enable & active;
		ctl.idx   = idx_q;
		cmd       = ctl.start ? cmd_t'(din) : cmd_q;
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			active <= 1'b0;
			cmd_q  <= '0;
			idx_q  <= '0;
		end else if (!enable) begin
			active <= 1'b0;
		end else if (ctl.start) begin
			active <= 1'b1;
			cmd_q  <= cmd_t'(din);
			idx_q  <= WORD_IDX_W'(1);
		end else if (ctl.word && !(&idx_q)) begin
			// saturate so long frames keep the last index
			idx_q <= idx_q + 1'b1;
		end
	end

endmodule

//--- design/uio_regs.sv
// user-I/O register file
// configuration, joysticks, status word and status-change readback
`timescale 1ns/100ps

module uio_regs import hps_pkg::*; (
	input  logic                clk_sys,
	input  logic                rst_n,
	input  frame_ctl_t          ctl,
	input  uio_cmd_t            cmd,
	input  logic [WORD_W-1:0]   din,
	input  logic [STATUS_W-1:0] status_in,
	input  logic                status_set,
	output logic [WORD_W-1:0]   io_dout,
	output ui_cfg_t             ui_cfg,
	output logic [JOY_W-1:0]    joystick_0,
	output logic [JOY_W-1:0]    joystick_1,
	output logic [STATUS_W-1:0] status
);

	logic                set_q;
	logic                set_rise;
	logic [3:0]          chg_cnt;
	logic [STATUS_W-1:0] status_req;
	logic [WORD_W-1:0]   rd_word;

	assign set_rise = status_set & ~set_q;

	// captured status quarters for the readback frame
	always_comb begin
		rd_word = '0;
		if (cmd == UIO_STATUS_REQ) begin
			case (ctl.idx)
				4'd1: rd_word = status_req[15:0];
				4'd2: rd_word = status_req[31:16];
				4'd3: rd_word = status_req[47:32];
				4'd4: rd_word = status_req[63:48];
				default: rd_word = '0;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (set_rise)
			status_req <= status_in;
	end

	//////////////////////////////////////////////////////////////////////
	// register writes and readback

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			set_q      <= 1'b0;
			chg_cnt    <= '0;
			io_dout    <= '0;
			ui_cfg     <= '0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			status     <= '0;
		end else begin
			set_q <= status_set;
			if (set_rise)
				chg_cnt <= chg_cnt + 1'b1;

			if (ctl.done) begin
				io_dout <= '0;
			end else if (ctl.start) begin
				// host polls this word to see how often the core changed status
				io_dout <= (cmd == UIO_STATUS_REQ) ? {8'h00, 4'hA, chg_cnt} : '0;
			end else if (ctl.word) begin
				io_dout <= rd_word;
				case (cmd)
					UIO_CFG: begin
						ui_cfg.buttons            <= din[1:0];
						ui_cfg.forced_scandoubler <= din[4];
						ui_cfg.direct_video       <= din[10];
					end
					UIO_JOY0: begin
						if (ctl.idx == 4'd1)
							joystick_0[15:0] <= din;
						else
							joystick_0[31:16] <= din;
					end
					UIO_JOY1: begin
						if (ctl.idx == 4'd1)
							joystick_1[15:0] <= din;
						else
							joystick_1[31:16] <= din;
					end
					UIO_STATUS: begin
						case (ctl.idx)
							4'd1: status[15:0]  <= din;
							4'd2: status[31:16] <= din;
							4'd3: status[47:32] <= din;
							4'd4: status[63:48] <= din;
							default: ;
						endcase
					end
					default: ;
				endcase
			end
		end
	end

endmodule

//--- design/kbd_decoder.sv
// keyboard scancode collector and key event decoder
`timescale 1ns/100ps

module kbd_decoder import hps_pkg::*; (
	input  logic              clk_sys,
	input  logic              rst_n,
	input  frame_ctl_t        ctl,
	input  uio_cmd_t          cmd,
	input  logic [WORD_W-1:0] din,
	output key_evt_t          ps2_key
);

	logic [31:0] raw;
	logic        skip;
	key_evt_t    evt;

	// break codes carry F0 before the key, extended keys carry E0
	always_comb begin
		evt.toggle   = ~ps2_key.toggle;
		evt.pressed  = (raw[15:8] != 8'hF0);
		evt.extended = evt.pressed ? (raw[15:8] == 8'hE0) : (raw[23:16] == 8'hE0);
		evt.code     = raw[7:0];
		case (raw)
			KEY_PRNSCR_DN: {evt.pressed, evt.extended, evt.code} = KEY_PRNSCR_DN_CODE;
			KEY_PRNSCR_UP: {evt.pressed, evt.extended, evt.code} = KEY_PRNSCR_UP_CODE;
			KEY_PAUSE_DN:  {evt.pressed, evt.extended, evt.code} = KEY_PAUSE_DN_CODE;
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (ctl.start && cmd == UIO_KBD)
			raw <= '0;
		else if (ctl.word && cmd == UIO_KBD && !(&din[15:8]))
			raw <= {raw[23:0], din[7:0]};
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			skip    <= 1'b0;
			ps2_key <= '0;
		end else begin
			if (ctl.start)
				skip <= 1'b0;
			// an FF high byte marks a frame meant for the PS/2 device only
			else if (ctl.word && cmd == UIO_KBD && (&din[15:8]))
				skip <= 1'b1;

			if (ctl.done && cmd == UIO_KBD && !skip)
				ps2_key <= evt;
		end
	end

endmodule

//--- design/file_loader.sv
// file download state
// index, download flag, address counter and byte writes to the core
`timescale 1ns/100ps

module file_loader import hps_pkg::*; (
	input  logic              clk_sys,
	input  logic              rst_n,
	input  frame_ctl_t        ctl,
	input  fio_cmd_t          cmd,
	input  logic [WORD_W-1:0] din,
	output ioctl_t            ioctl
);

	logic [ADDR_W-1:0] addr_q;
	logic              dat_accept;

	// data words outside a download are dropped
	assign dat_accept = ctl.word && cmd == FIO_FILE_TX_DAT && ioctl.download;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			ioctl  <= '0;
			addr_q <= '0;
		end else begin
			// one write pulse per accepted data word
			ioctl.wr <= dat_accept;

			if (ctl.word) begin
				case (cmd)
					FIO_FILE_INDEX: begin
						ioctl.index <= din;
					end
					FIO_FILE_TX: begin
						case (ctl.idx)
							4'd1: begin
								if (din[7:0] != 8'h00) begin
									ioctl.download <= 1'b1;
									addr_q         <= '0;
								end else begin
									ioctl.download <= 1'b0;
								end
							end
							4'd2: addr_q[15:0] <= din;
							4'd3: addr_q[ADDR_W-1:16] <= din[ADDR_W-17:0];
							default: ;
						endcase
					end
					FIO_FILE_TX_DAT: begin
						if (ioctl.download) begin
							ioctl.addr <= addr_q;
							ioctl.dout <= din[7:0];
							addr_q     <= addr_q + 1'b1;
						end
					end
					default: ;
				endcase
			end
		end
	end

endmodule

//--- design/hps_link_top.sv
// host-link endpoint top level
// two command framers feeding the user-I/O, keyboard and file blocks
`timescale 1ns/100ps

module hps_link_top import hps_pkg::*; (
	input  logic                clk_sys,
	input  logic                rst_n,
	input  hps_bus_t            hps,
	output logic [WORD_W-1:0]   io_dout,
	input  logic [STATUS_W-1:0] status_in,
	input  logic                status_set,
	output logic [JOY_W-1:0]    joystick_0,
	output logic [JOY_W-1:0]    joystick_1,
	output logic [STATUS_W-1:0] status,
	output ui_cfg_t             ui_cfg,
	output key_evt_t            ps2_key,
	output ioctl_t              ioctl
);

	frame_ctl_t uio_ctl;
	uio_cmd_t   uio_cmd;
	frame_ctl_t fio_ctl;
	fio_cmd_t   fio_cmd;

	//////////////////////////////////////////////////////////////////////
	// channel framers

	cmd_framer #(.cmd_t(uio_cmd_t)) u_uio_framer (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.enable  (hps.io_enable),
		.strobe  (hps.io_strobe),
		.din     (hps.io_din),
		.ctl     (uio_ctl),
		.cmd     (uio_cmd)
	);

	cmd_framer #(.cmd_t(fio_cmd_t)) u_fio_framer (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.enable  (hps.fp_enable),
		.strobe  (hps.io_strobe),
		.din     (hps.io_din),
		.ctl     (fio_ctl),
		.cmd     (fio_cmd)
	);

	//////////////////////////////////////////////////////////////////////
	// channel blocks

	uio_regs u_uio_regs (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.ctl        (uio_ctl),
		.cmd        (uio_cmd),
		.din        (hps.io_din),
		.status_in  (status_in),
		.status_set (status_set),
		.io_dout    (io_dout),
		.ui_cfg     (ui_cfg),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.status     (status)
	);

	kbd_decoder u_kbd_decoder (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.ctl     (uio_ctl),
		.cmd     (uio_cmd),
		.din     (hps.io_din),
		.ps2_key (ps2_key)
	);

	file_loader u_file_loader (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.ctl     (fio_ctl),
		.cmd     (fio_cmd),
		.din     (hps.io_din),
		.ioctl   (ioctl)
	);

endmodule

//--- test/hps_link_checker.sv
// checker for the host-link testbench
// compares a selected DUT output on request and logs ioctl byte writes
`timescale 1ns/100ps

module hps_link_checker import hps_pkg::*; (
	input  logic                clk_sys,
	input  logic                rst_n,
	input  logic                chk,
	input  logic [95:0]         name,
	input  logic [3:0]          field,
	input  logic [63:0]         expected,
	input  logic [WORD_W-1:0]   io_dout,
	input  logic [JOY_W-1:0]    joystick_0,
	input  logic [JOY_W-1:0]    joystick_1,
	input  logic [STATUS_W-1:0] status,
	input  ui_cfg_t             ui_cfg,
	input  key_evt_t            ps2_key,
	input  ioctl_t              ioctl,
	output int                  val_errs,
	output int                  other_errs
);

	localparam logic [3:0] F_CFG    = 4'd0;
	localparam logic [3:0] F_JOY0   = 4'd1;
	localparam logic [3:0] F_JOY1   = 4'd2;
	localparam logic [3:0] F_STATUS = 4'd3;
	localparam logic [3:0] F_DOUT   = 4'd4;
	localparam logic [3:0] F_KEY    = 4'd5;
	localparam logic [3:0] F_INDEX  = 4'd6;
	localparam logic [3:0] F_DL     = 4'd7;
	localparam logic [3:0] F_WR     = 4'd8;

	logic [ADDR_W-1:0] wr_addr [$];
	logic [7:0]        wr_byte [$];

	function automatic logic [63:0] field_value(input logic [3:0] f);
		case (f)
			F_CFG:    return {60'd0, ui_cfg};
			F_JOY0:   return {32'd0, joystick_0};
			F_JOY1:   return {32'd0, joystick_1};
			F_STATUS: return status;
			F_DOUT:   return {48'd0, io_dout};
			F_KEY:    return {53'd0, ps2_key};
			F_INDEX:  return {48'd0, ioctl.index};
			F_DL:     return {63'd0, ioctl.download};
			default:  return 64'd0;
		endcase
	endfunction

	// expected holds count in 62:59, start address in 58:32, bytes from bit 0 up
	task automatic check_writes;
		int                n;
		logic [ADDR_W-1:0] base;
		logic [34:0]       want;
		n    = int'(expected[62:59]);
		base = expected[58:32];
		if (wr_addr.size() != n) begin
			$display("%0s: expected %0d byte writes to the core, saw %0d",
				name, n, wr_addr.size());
			other_errs++;
		end else begin
			for (int i = 0; i < n; i++) begin
				want = {base + ADDR_W'(i), expected[8*i +: 8]};
				if ({wr_addr[i], wr_byte[i]} !== want) begin
					$display("ERR %0s: expected %h, actual %h",
						name, want, {wr_addr[i], wr_byte[i]});
					val_errs++;
				end
			end
		end
		wr_addr.delete();
		wr_byte.delete();
	endtask

	initial begin
		val_errs   = 0;
		other_errs = 0;
	end

	always @(posedge clk_sys) begin
		if (rst_n && ioctl.wr) begin
			wr_addr.push_back(ioctl.addr);
			wr_byte.push_back(ioctl.dout);
		end
		if (chk) begin
			if (field == F_WR) begin
				check_writes();
			end else if (field_value(field) !== expected) begin
				$display("ERR %0s: expected %h, actual %h", name, expected, field_value(field));
				val_errs++;
			end
		end
	end

endmodule

//--- test/tb_hps_link.sv
// testbench top for the host-link endpoint
// clock, reset, frame table, driving loop and watchdog
`timescale 1ns/100ps

module tb_hps_link import hps_pkg::*; ();

	localparam int N_ROWS = 18;
	localparam logic CH_IO = 1'b0;
	localparam logic CH_FP = 1'b1;

	localparam logic [3:0] F_CFG    = 4'd0;
	localparam logic [3:0] F_JOY0   = 4'd1;
	localparam logic [3:0] F_JOY1   = 4'd2;
	localparam logic [3:0] F_STATUS = 4'd3;
	localparam logic [3:0] F_DOUT   = 4'd4;
	localparam logic [3:0] F_KEY    = 4'd5;
	localparam logic [3:0] F_INDEX  = 4'd6;
	localparam logic [3:0] F_DL     = 4'd7;
	localparam logic [3:0] F_WR     = 4'd8;
	localparam logic [3:0] F_RDBK   = 4'd9;

	// one frame and the value expected after it
	typedef struct packed {
		logic [95:0]      name;
		logic             chan;
		logic [15:0]      cmd;
		logic [2:0]       nw;
		logic [3:0][15:0] w;
		logic [1:0]       pulses;
		logic [63:0]      stat_val;
		logic [3:0]       field;
		logic [63:0]      exp;
	} row_t;

	logic                clk_sys;
	logic                rst_n;
	hps_bus_t            hps;
	logic [STATUS_W-1:0] status_in;
	logic                status_set;
	logic [WORD_W-1:0]   io_dout;
	logic [JOY_W-1:0]    joystick_0;
	logic [JOY_W-1:0]    joystick_1;
	logic [STATUS_W-1:0] status;
	ui_cfg_t             ui_cfg;
	key_evt_t            ps2_key;
	ioctl_t              ioctl;

	logic        chk;
	logic [95:0] chk_name;
	logic [3:0]  chk_field;
	logic [63:0] chk_exp;
	int          val_errs;
	int          other_errs;
	integer      seed = 32'hf57d_fbb6;
	row_t        rows [N_ROWS];

	hps_link_top hps_link_top_i (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.hps        (hps),
		.io_dout    (io_dout),
		.status_in  (status_in),
		.status_set (status_set),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.status     (status),
		.ui_cfg     (ui_cfg),
		.ps2_key    (ps2_key),
		.ioctl      (ioctl)
	);

	hps_link_checker u_checker (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.chk        (chk),
		.name       (chk_name),
		.field      (chk_field),
		.expected   (chk_exp),
		.io_dout    (io_dout),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.status     (status),
		.ui_cfg     (ui_cfg),
		.ps2_key    (ps2_key),
		.ioctl      (ioctl),
		.val_errs   (val_errs),
		.other_errs (other_errs)
	);

	always #50 clk_sys = ~clk_sys;

	function automatic row_t table_row(input logic [95:0] nm, input logic ch,
		input logic [15:0] c, input int n, input logic [63:0] words,
		input logic [3:0] f, input logic [63:0] e);
		row_t r;
		r = '0;
		r.name  = nm;
		r.chan  = ch;
		r.cmd   = c;
		r.nw    = 3'(n);
		r.w     = words;
		r.field = f;
		r.exp   = e;
		return r;
	endfunction

	function automatic logic [63:0] key_value(input logic tg, input logic p, input logic e,
		input logic [7:0] code);
		return {53'd0, tg, p, e, code};
	endfunction

	// data byte in the low half, filler in the high half
	function automatic logic [63:0] data_words(input logic [31:0] h, input logic [31:0] d);
		logic [63:0] wd;
		for (int i = 0; i < 4; i++)
			wd[16*i +: 16] = {h[8*i +: 8], d[8*i +: 8]};
		return wd;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// frame table

	task automatic build_table;
		logic [15:0]       cfg_w;
		logic [31:0]       j;
		logic [63:0]       s;
		logic [63:0]       sv;
		logic [31:0]       d;
		logic [31:0]       h;
		logic [ADDR_W-1:0] base;
		logic              tg;
		cfg_w = 16'h0412;
		rows[0] = table_row("cfg", CH_IO, UIO_CFG, 1, {48'd0, cfg_w}, F_CFG,
			{60'd0, cfg_w[1:0], cfg_w[4], cfg_w[10]});
		j = $random(seed);
		rows[1] = table_row("joy0", CH_IO, UIO_JOY0, 2, {32'd0, j}, F_JOY0, {32'd0, j});
		j = $random(seed);
		rows[2] = table_row("joy1", CH_IO, UIO_JOY1, 2, {32'd0, j}, F_JOY1, {32'd0, j});
		s = {$random(seed), $random(seed)};
		rows[3] = table_row("status", CH_IO, UIO_STATUS, 4, s, F_STATUS, s);
		sv = {$random(seed), $random(seed)};
		rows[4] = table_row("chg_count", CH_IO, UIO_STATUS_REQ, 0, 64'd0, F_DOUT,
			{48'd0, 16'h00A0 + 16'd3});
		rows[4].pulses   = 2'd3;
		rows[4].stat_val = sv;
		// third pulse drives sv ^ 2
		rows[5] = table_row("chg_data", CH_IO, UIO_STATUS_REQ, 4, 64'd0, F_RDBK, sv ^ 64'd2);

		tg = 1'b1;
		rows[6] = table_row("key_make", CH_IO, UIO_KBD, 1, 64'h001C, F_KEY,
			key_value(tg, 1'b1, 1'b0, 8'h1C));
		tg = ~tg;
		rows[7] = table_row("key_break", CH_IO, UIO_KBD, 2, 64'h001C_00F0, F_KEY,
			key_value(tg, 1'b0, 1'b0, 8'h1C));
		tg = ~tg;
		rows[8] = table_row("key_ext", CH_IO, UIO_KBD, 2, 64'h0075_00E0, F_KEY,
			key_value(tg, 1'b1, 1'b1, 8'h75));
		tg = ~tg;
		rows[9] = table_row("key_prnscr", CH_IO, UIO_KBD, 4, 64'h007C_00E0_0012_00E0, F_KEY,
			{53'd0, tg, 10'h37C});
		rows[10] = table_row("key_skip", CH_IO, UIO_KBD, 2, 64'h0034_FF12, F_KEY, rows[9].exp);
		tg = ~tg;
		rows[11] = table_row("key_brk_ext", CH_IO, UIO_KBD, 3, 64'h0075_00F0_00E0, F_KEY,
			key_value(tg, 1'b0, 1'b1, 8'h75));

		rows[12] = table_row("file_index", CH_FP, {8'h00, FIO_FILE_INDEX}, 1, 64'h1A07,
			F_INDEX, 64'h1A07);
		base = {11'h123, 16'h4567};
		rows[13] = table_row("dl_start", CH_FP, {8'h00, FIO_FILE_TX}, 3, 64'h0123_4567_0001,
			F_DL, 64'd1);
		d = $random(seed);
		h = $random(seed);
		rows[14] = table_row("dl_data", CH_FP, {8'h00, FIO_FILE_TX_DAT}, 4, data_words(h, d),
			F_WR, {1'b0, 4'd4, base, d});
		d = $random(seed);
		h = $random(seed);
		rows[15] = table_row("dl_data2", CH_FP, {8'h00, FIO_FILE_TX_DAT}, 2, data_words(h, d),
			F_WR, {1'b0, 4'd2, base + 27'd4, 16'd0, d[15:0]});
		// only the low byte of word 1 matters
		rows[16] = table_row("dl_stop", CH_FP, {8'h00, FIO_FILE_TX}, 1, 64'hAB00, F_DL, 64'd0);
		rows[17] = table_row("dl_after", CH_FP, {8'h00, FIO_FILE_TX_DAT}, 2, data_words(h, d),
			F_WR, 64'd0);
	endtask

	//////////////////////////////////////////////////////////////////////
	// bus driving

	task automatic send_word(input logic [15:0] w);
		hps.io_strobe <= 1'b1;
		hps.io_din    <= w;
		@(posedge clk_sys);
		hps.io_strobe <= 1'b0;
		@(posedge clk_sys);
	endtask

	task automatic check_field(input logic [95:0] nm, input logic [3:0] f, input logic [63:0] e);
		chk       <= 1'b1;
		chk_name  <= nm;
		chk_field <= f;
		chk_exp   <= e;
		@(posedge clk_sys);
		chk <= 1'b0;
	endtask

	task automatic run_row(input row_t r);
		for (int p = 0; p < r.pulses; p++) begin
			status_in  <= r.stat_val ^ 64'(p);
			status_set <= 1'b1;
			repeat (2) @(posedge clk_sys);
			// status_in moves on once the request has been taken
			status_in  <= ~r.stat_val;
			status_set <= 1'b0;
			@(posedge clk_sys);
		end
		if (r.chan == CH_IO)
			hps.io_enable <= 1'b1;
		else
			hps.fp_enable <= 1'b1;
		send_word(r.cmd);
		for (int k = 0; k < r.nw; k++) begin
			send_word(r.w[k]);
			// readback quarters come low to high
			if (r.field == F_RDBK)
				check_field(r.name, F_DOUT, {48'd0, r.exp[16*k +: 16]});
		end
		if (r.field == F_DOUT)
			check_field(r.name, F_DOUT, r.exp);
		hps.io_enable <= 1'b0;
		hps.fp_enable <= 1'b0;
		repeat (4) @(posedge clk_sys);
		if (r.field == F_RDBK)
			check_field(r.name, F_DOUT, 64'd0);
		else if (r.field != F_DOUT)
			check_field(r.name, r.field, r.exp);
	endtask

	initial begin
		clk_sys    = 1'b0;
		rst_n      = 1'b0;
		hps        = '0;
		status_in  = '0;
		status_set = 1'b0;
		chk        = 1'b0;
		chk_name   = '0;
		chk_field  = '0;
		chk_exp    = '0;
		build_table();
		repeat (8) @(posedge clk_sys);
		rst_n <= 1'b1;
		repeat (2) @(posedge clk_sys);
		for (int i = 0; i < N_ROWS; i++)
			run_row(rows[i]);
		repeat (2) @(posedge clk_sys);
		$display("errors: %0d value mismatches, %0d other failures", val_errs, other_errs);
		if (val_errs == 0 && other_errs == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	// watchdog
	initial begin
		repeat (N_ROWS * 20 + 50) @(posedge clk_sys);
		$display("watchdog expired, frame table not done after %0d cycles", N_ROWS * 20 + 50);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

//--- project.f
design/hps_pkg.sv
design/cmd_framer.sv
design/uio_regs.sv
design/kbd_decoder.sv
design/file_loader.sv
design/hps_link_top.sv
test/hps_link_checker.sv
test/tb_hps_link.sv

//--- Bender.yml
package:
  name: hps_link

sources:
  - design/hps_pkg.sv
  - design/cmd_framer.sv
  - design/uio_regs.sv
  - design/kbd_decoder.sv
  - design/file_loader.sv
  - design/hps_link_top.sv
  - target: test
    files:
      - test/hps_link_checker.sv
      - test/tb_hps_link.sv
